// File: include/ghash_config.svh
`ifndef GHASH_CONFIG_SVH
`define GHASH_CONFIG_SVH

// --------------------------------------------------
// GHASH engine sizing
// --------------------------------------------------

// One GCM block, also one GF(2^128) element
`define GHASH_BLOCK_W 128

// Bit-length field of the GCM lengths block
`define GHASH_LEN_W 64

// Byte enables per stream beat
`define GHASH_KEEP_W 16

// Framed blocks buffered between framer and accumulator
`define GHASH_FIFO_DEPTH 4

`endif

// File: source/ghash_pkg.sv
`include "ghash_config.svh"

package ghash_pkg;

    // --------------------------------------------------
    // Vector types
    // --------------------------------------------------

    // Bit 127 is the first bit of the block in GCM order
    typedef logic [`GHASH_BLOCK_W-1:0] gf_block_t;
    typedef logic [`GHASH_LEN_W-1:0]   bit_len_t;
    // keep[i] gates bits 8i+7..8i
    typedef logic [`GHASH_KEEP_W-1:0]  byte_keep_t;

    // --------------------------------------------------
    // Stream and block records
    // --------------------------------------------------

    // Input beat, shared by the AAD and ciphertext streams
    typedef struct packed {
        gf_block_t  data;
        byte_keep_t keep;
        logic       last;
    } stream_beat_t;

    // Block handed to the accumulator
    typedef struct packed {
        gf_block_t data;
        logic      first;
        logic      last;
    } framed_block_t;

    // Framer sequencing
    typedef enum logic [1:0] {
        PH_IDLE,
        PH_AAD,
        PH_CT,
        PH_LEN
    } frame_phase_t;

endpackage

// File: source/ghash_block_framer.sv
`timescale 1ns/100ps

`include "ghash_config.svh"

module ghash_block_framer
    import ghash_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          start,
    input  bit_len_t      len_aad_bits,
    input  bit_len_t      len_ct_bits,
    input  stream_beat_t  aad,
    input  logic          aad_valid,
    input  stream_beat_t  ct,
    input  logic          ct_valid,
    input  logic          push_ready,
    output logic          aad_ready,
    output logic          ct_ready,
    output framed_block_t push_blk,
    output logic          push_valid,
    output logic          framer_busy
);

    frame_phase_t phase_q;
    frame_phase_t phase_d;
    bit_len_t     len_aad_q;
    bit_len_t     len_ct_q;
    logic         first_q;
    logic         start_take;
    logic         aad_fire;
    logic         ct_fire;
    logic         push_fire;

    // Bytes with a low keep bit contribute zeros to the hash
    function automatic gf_block_t mask_bytes(input gf_block_t data, input byte_keep_t keep);
        gf_block_t masked;
        for (int i = 0; i < `GHASH_KEEP_W; i++) begin
            masked[8*i +: 8] = keep[i] ? data[8*i +: 8] : 8'h00;
        end
        return masked;
    endfunction

    // --------------------------------------------------
    // Handshakes
    // --------------------------------------------------
    assign start_take = start && (phase_q == PH_IDLE);
    assign aad_ready  = (phase_q == PH_AAD) && push_ready;
    assign ct_ready   = (phase_q == PH_CT) && push_ready;
    assign aad_fire   = aad_valid && aad_ready;
    assign ct_fire    = ct_valid && ct_ready;
    assign push_fire  = push_valid && push_ready;

    assign framer_busy = (phase_q != PH_IDLE);

    // --------------------------------------------------
    // Phase sequencing
    // --------------------------------------------------
    always_comb begin
        phase_d = phase_q;
        case (phase_q)
            PH_IDLE: begin
                // empty sections are skipped right away
                if (start_take) begin
                    if (len_aad_bits != '0) begin
                        phase_d = PH_AAD;
                    end else if (len_ct_bits != '0) begin
                        phase_d = PH_CT;
                    end else begin
                        phase_d = PH_LEN;
                    end
                end
            end
            PH_AAD: begin
                if (aad_fire && aad.last) begin
                    phase_d = (len_ct_q != '0) ? PH_CT : PH_LEN;
                end
            end
            PH_CT: begin
                if (ct_fire && ct.last) begin
                    phase_d = PH_LEN;
                end
            end
            PH_LEN: begin
                if (push_ready) begin
                    phase_d = PH_IDLE;
                end
            end
            default: begin
                phase_d = PH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_q   <= PH_IDLE;
            len_aad_q <= '0;
            len_ct_q  <= '0;
            first_q   <= 1'b0;
        end else begin
            phase_q <= phase_d;
            if (start_take) begin
                len_aad_q <= len_aad_bits;
                len_ct_q  <= len_ct_bits;
                first_q   <= 1'b1;
            end else if (push_fire) begin
                first_q <= 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // Block formation
    // --------------------------------------------------
    always_comb begin
        push_valid     = 1'b0;
        push_blk       = '0;
        push_blk.first = first_q;
        case (phase_q)
            PH_AAD: begin
                push_valid    = aad_valid;
                push_blk.data = mask_bytes(aad.data, aad.keep);
            end
            PH_CT: begin
                push_valid    = ct_valid;
                push_blk.data = mask_bytes(ct.data, ct.keep);
            end
            PH_LEN: begin
                // GCM lengths block, AAD length in the upper half
                push_valid    = 1'b1;
                push_blk.data = {len_aad_q, len_ct_q};
                push_blk.last = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------

    // Host drops AAD once the framer has moved on to ciphertext or lengths
    assert property (@(posedge clk) disable iff (!rst_n)
        (phase_q == PH_CT || phase_q == PH_LEN) |-> !aad_valid)
        else $error("aad_valid high outside the AAD section");

    // Beats offered between messages would never reach the FIFO
    assert property (@(posedge clk) disable iff (!rst_n)
        (phase_q == PH_IDLE) |-> !(aad_valid || ct_valid))
        else $error("stream valid high while idle");

endmodule

// File: source/ghash_block_fifo.sv
`timescale 1ns/100ps

`include "ghash_config.svh"

module ghash_block_fifo
    import ghash_pkg::*;
#(
    parameter int DEPTH = `GHASH_FIFO_DEPTH
)
(
    input  logic          clk,
    input  logic          rst_n,
    input  framed_block_t push_blk,
    input  logic          push_valid,
    input  logic          pop_ready,
    output logic          push_ready,
    output framed_block_t pop_blk,
    output logic          pop_valid
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    framed_block_t    mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push_fire;
    logic             pop_fire;

    // Pointer advance with wrap for any depth
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push_ready = (count != CNT_W'(DEPTH));
    assign pop_valid  = (count != '0);
    assign push_fire  = push_valid && push_ready;
    assign pop_fire   = pop_valid && pop_ready;

    // Head of queue is visible the cycle after its push
    assign pop_blk = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push_fire) begin
            mem[wr_ptr] <= push_blk;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop_fire) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push_fire, pop_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------

    // Overrun or underrun would leave the pointers skewed at full or empty
    assert property (@(posedge clk) disable iff (!rst_n)
        (count == '0 || count == CNT_W'(DEPTH)) |-> (wr_ptr == rd_ptr))
        else $error("FIFO pointers out of step with count");

    // Head entry waits unchanged until the accumulator takes it
    assert property (@(posedge clk) disable iff (!rst_n)
        (pop_valid && !pop_ready) |=> (pop_valid && $stable(pop_blk)))
        else $error("FIFO head changed before it was popped");

endmodule

// File: source/ghash_accumulator.sv
`timescale 1ns/100ps

`include "ghash_config.svh"

module ghash_accumulator
    import ghash_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  gf_block_t     hash_key,
    input  framed_block_t pop_blk,
    input  logic          pop_valid,
    output logic          pop_ready,
    output gf_block_t     tag,
    output logic          tag_valid,
    output logic          msg_open
);

    localparam int CNT_W = $clog2(`GHASH_BLOCK_W);

    // Reduction constant, E1 followed by zeros
    localparam gf_block_t GF_R = {8'he1, {(`GHASH_BLOCK_W - 8){1'b0}}};

    typedef enum logic [1:0] {
        ACC_BOOT,
        ACC_IDLE,
        ACC_MUL
    } acc_state_t;

    acc_state_t       state_q;
    logic [CNT_W-1:0] bit_cnt_q;
    logic             last_q;
    logic             msg_open_q;
    gf_block_t        tag_q;
    logic             tag_valid_q;

    // Datapath: running hash, multiplier operand, Z, V and captured key
    gf_block_t        y_q;
    gf_block_t        x_q;
    gf_block_t        z_q;
    gf_block_t        v_q;
    gf_block_t        h_q;

    gf_block_t        z_next;
    gf_block_t        v_next;
    logic             pop_fire;
    logic             mul_done;

    assign pop_ready = (state_q == ACC_IDLE);
    assign pop_fire  = pop_valid && pop_ready;
    assign mul_done  = (state_q == ACC_MUL) && (bit_cnt_q == '1);

    // --------------------------------------------------
    // One step of the GCM multiply
    // --------------------------------------------------
    // Operand is walked from bit 127 down by shifting it left
    assign z_next = x_q[`GHASH_BLOCK_W-1] ? (z_q ^ v_q) : z_q;
    assign v_next = v_q[0] ? ((v_q >> 1) ^ GF_R) : (v_q >> 1);

    always_ff @(posedge clk) begin
        if (pop_fire) begin
            x_q <= pop_blk.first ? pop_blk.data : (y_q ^ pop_blk.data);
            v_q <= pop_blk.first ? hash_key : h_q;
            z_q <= '0;
            if (pop_blk.first) begin
                h_q <= hash_key;
            end
        end else if (state_q == ACC_MUL) begin
            x_q <= x_q << 1;
            v_q <= v_next;
            z_q <= z_next;
            if (mul_done) begin
                y_q <= z_next;
            end
        end
    end

    // --------------------------------------------------
    // Control
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= ACC_BOOT;
            bit_cnt_q   <= '0;
            last_q      <= 1'b0;
            msg_open_q  <= 1'b0;
            tag_q       <= '0;
            tag_valid_q <= 1'b0;
        end else begin
            tag_valid_q <= 1'b0;
            case (state_q)
                ACC_BOOT: begin
                    state_q <= ACC_IDLE;
                end
                ACC_IDLE: begin
                    if (pop_fire) begin
                        state_q   <= ACC_MUL;
                        bit_cnt_q <= '0;
                        last_q    <= pop_blk.last;
                        if (pop_blk.first) begin
                            msg_open_q <= 1'b1;
                            tag_q      <= '0;
                        end
                    end
                end
                ACC_MUL: begin
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                    if (mul_done) begin
                        state_q <= ACC_IDLE;
                        // lengths block done, Y is the tag
                        if (last_q) begin
                            tag_q       <= z_next;
                            tag_valid_q <= 1'b1;
                            msg_open_q  <= 1'b0;
                        end
                    end
                end
                default: begin
                    state_q <= ACC_IDLE;
                end
            endcase
        end
    end

    // A first block waiting at the FIFO head already opens the message
    assign msg_open  = msg_open_q || (pop_valid && pop_blk.first);
    assign tag       = tag_q;
    assign tag_valid = tag_valid_q;

    // Single-cycle tag strobe, value held afterwards
    assert property (@(posedge clk) disable iff (!rst_n)
        tag_valid |=> (!tag_valid && $stable(tag)))
        else $error("tag_valid longer than one cycle or tag moved");

endmodule

// File: source/ghash_engine_top.sv
`timescale 1ns/100ps

`include "ghash_config.svh"

module ghash_engine_top
    import ghash_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         start,
    input  bit_len_t     len_aad_bits,
    input  bit_len_t     len_ct_bits,
    input  gf_block_t    hash_key,
    input  stream_beat_t aad,
    input  logic         aad_valid,
    output logic         aad_ready,
    input  stream_beat_t ct,
    input  logic         ct_valid,
    output logic         ct_ready,
    output gf_block_t    tag,
    output logic         tag_valid,
    output logic         busy
);

    framed_block_t push_blk;
    logic          push_valid;
    logic          push_ready;
    framed_block_t pop_blk;
    logic          pop_valid;
    logic          pop_ready;
    logic          framer_busy;
    logic          msg_open;
    logic          start_ok;

    // --------------------------------------------------
    // Status
    // --------------------------------------------------
    assign busy     = framer_busy | msg_open;
    // Start is dropped while a message is still open
    assign start_ok = start & ~busy;

    ghash_block_framer u_framer (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start_ok),
        .len_aad_bits (len_aad_bits),
        .len_ct_bits  (len_ct_bits),
        .aad          (aad),
        .aad_valid    (aad_valid),
        .ct           (ct),
        .ct_valid     (ct_valid),
        .push_ready   (push_ready),
        .aad_ready    (aad_ready),
        .ct_ready     (ct_ready),
        .push_blk     (push_blk),
        .push_valid   (push_valid),
        .framer_busy  (framer_busy)
    );

    ghash_block_fifo #(
        .DEPTH (`GHASH_FIFO_DEPTH)
    ) u_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .push_blk   (push_blk),
        .push_valid (push_valid),
        .pop_ready  (pop_ready),
        .push_ready (push_ready),
        .pop_blk    (pop_blk),
        .pop_valid  (pop_valid)
    );

    ghash_accumulator u_accum (
        .clk       (clk),
        .rst_n     (rst_n),
        .hash_key  (hash_key),
        .pop_blk   (pop_blk),
        .pop_valid (pop_valid),
        .pop_ready (pop_ready),
        .tag       (tag),
        .tag_valid (tag_valid),
        .msg_open  (msg_open)
    );

endmodule

// File: tb/tb_ghash_engine.sv
`timescale 1ns/100ps

`include "ghash_config.svh"

module tb_ghash_engine
    import ghash_pkg::*;
();

    localparam int NUM_ROWS     = 7;
    localparam int MAX_BEATS    = 8;
    localparam int BEAT_TIMEOUT = 500;
    localparam int TAG_TIMEOUT  = 2000;

    // Reduction constant of the GCM field
    localparam gf_block_t GF_R      = {8'he1, 120'h0};
    // GCM test case 2, zero key
    localparam gf_block_t TC2_CT    = 128'h0388dace60b6a392f328c2b971b2fe78;
    localparam gf_block_t TC2_GHASH = 128'hf38cbb1ad69223dcc3457ae5b6b0f885;

    typedef struct packed {
        gf_block_t   h;
        logic [7:0]  n_aad;
        logic [7:0]  n_ct;
        byte_keep_t  aad_keep;
        byte_keep_t  ct_keep;
        logic [31:0] seed;
        logic        fixed_ct;
        logic        extra_start;
    } test_row_t;

    logic         clk = 1'b0;
    logic         rst_n;
    logic         start;
    bit_len_t     len_aad_bits;
    bit_len_t     len_ct_bits;
    gf_block_t    hash_key;
    stream_beat_t aad;
    logic         aad_valid;
    logic         aad_ready;
    stream_beat_t ct;
    logic         ct_valid;
    logic         ct_ready;
    gf_block_t    tag;
    logic         tag_valid;
    logic         busy;

    test_row_t    rows [NUM_ROWS];
    gf_block_t    aad_mem [MAX_BEATS];
    gf_block_t    ct_mem [MAX_BEATS];
    logic [31:0]  rand_state;
    int           err_count;
    int           timeout_count;
    int           stall_count;
    logic         aborted;

    always #5 clk = ~clk;

    ghash_engine_top DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .len_aad_bits (len_aad_bits),
        .len_ct_bits  (len_ct_bits),
        .hash_key     (hash_key),
        .aad          (aad),
        .aad_valid    (aad_valid),
        .aad_ready    (aad_ready),
        .ct           (ct),
        .ct_valid     (ct_valid),
        .ct_ready     (ct_ready),
        .tag          (tag),
        .tag_valid    (tag_valid),
        .busy         (busy)
    );

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------

    // GCM product, operand walked from bit 127 down
    function automatic gf_block_t gf_mult(input gf_block_t x, input gf_block_t y);
        gf_block_t z;
        gf_block_t v;
        z = '0;
        v = y;
        for (int i = 127; i >= 0; i--) begin
            if (x[i]) begin
                z = z ^ v;
            end
            v = v[0] ? ((v >> 1) ^ GF_R) : (v >> 1);
        end
        return z;
    endfunction

    function automatic gf_block_t apply_keep(input gf_block_t d, input byte_keep_t k);
        gf_block_t m;
        for (int b = 0; b < `GHASH_KEEP_W; b++) begin
            m[8*b +: 8] = k[b] ? d[8*b +: 8] : 8'h00;
        end
        return m;
    endfunction

    function automatic bit_len_t section_bits(input int n, input byte_keep_t last_keep);
        if (n == 0) begin
            return '0;
        end
        return bit_len_t'((n - 1) * 128 + $countones(last_keep) * 8);
    endfunction

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw_block(output gf_block_t blk);
        for (int w = 0; w < 4; w++) begin
            rand_state = next_rand(rand_state);
            blk[32*w +: 32] = rand_state;
        end
    endtask

    // --------------------------------------------------
    // Stream driving and tag collection
    // --------------------------------------------------
    task automatic send_beat(input logic to_ct, input gf_block_t data, input byte_keep_t keep,
                             input logic last_beat, output logic ok);
        stream_beat_t beat;
        int           waited;
        logic         taken;
        beat.data = data;
        beat.keep = keep;
        beat.last = last_beat;
        waited    = 0;
        taken     = 1'b0;
        ok        = 1'b1;
        if (to_ct) begin
            ct       = beat;
            ct_valid = 1'b1;
        end else begin
            aad       = beat;
            aad_valid = 1'b1;
        end
        while (!taken && ok) begin
            @(negedge clk);
            if (to_ct ? ct_ready : aad_ready) begin
                taken = 1'b1;
            end else begin
                stall_count++;
                waited++;
                if (waited >= BEAT_TIMEOUT) begin
                    $display("Timeout: a %s beat was never accepted",
                             to_ct ? "ciphertext" : "AAD");
                    ok = 1'b0;
                end
            end
            @(posedge clk);
            #1;
        end
        aad_valid = 1'b0;
        ct_valid  = 1'b0;
    endtask

    // Extra start lands while the accumulator still holds the message
    task automatic wait_tag(input gf_block_t expected, input logic extra_start, output logic ok);
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        ok     = 1'b1;
        while (!seen && ok) begin
            @(posedge clk);
            #1;
            start = extra_start && (waited == 3);
            if (start) begin
                len_aad_bits = '0;
                len_ct_bits  = '0;
            end
            @(negedge clk);
            if (tag_valid) begin
                seen = 1'b1;
            end else begin
                waited++;
                if (waited >= TAG_TIMEOUT) begin
                    $display("Timeout: tag_valid never arrived");
                    ok = 1'b0;
                end
            end
        end
        if (seen) begin
            if (tag !== expected) begin
                $display("ERR tag: got %h, expected %h", tag, expected);
                err_count++;
            end
            if (busy !== 1'b0) begin
                $display("ERR busy: got %h, expected %h", busy, 1'b0);
                err_count++;
            end
            repeat (2) @(negedge clk);
            if (tag !== expected) begin
                $display("ERR tag after pulse: got %h, expected %h", tag, expected);
                err_count++;
            end
            if (busy !== 1'b0) begin
                $display("ERR busy after pulse: got %h, expected %h", busy, 1'b0);
                err_count++;
            end
            @(posedge clk);
            #1;
        end
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        gf_block_t  y;
        gf_block_t  blk;
        gf_block_t  expected;
        bit_len_t   la;
        bit_len_t   lc;
        byte_keep_t k;
        logic       ok;
        int         n_aad;
        int         n_ct;

        rst_n         = 1'b0;
        start         = 1'b0;
        len_aad_bits  = '0;
        len_ct_bits   = '0;
        hash_key      = '0;
        aad           = '0;
        aad_valid     = 1'b0;
        ct            = '0;
        ct_valid      = 1'b0;
        err_count     = 0;
        timeout_count = 0;
        stall_count   = 0;
        aborted       = 1'b0;
        rand_state    = 32'hbae0;

        // H, AAD beats, CT beats, AAD last keep, CT last keep, seed, TC2 data, extra start
        rows[0] = '{128'h66e94bd4ef8a2c3b884cfa59ca342b2e, 8'd0, 8'd1, 16'h0000, 16'hffff,
                    32'h1, 1'b1, 1'b0};
        rows[1] = '{128'hb83b533708bf535d0aa6e52980d53b78, 8'd2, 8'd3, 16'hfff0, 16'hff80,
                    32'h2, 1'b0, 1'b0};
        rows[2] = '{128'h25629347589242761d31f826ba4b757b, 8'd0, 8'd0, 16'h0000, 16'h0000,
                    32'h3, 1'b0, 1'b1};
        rows[3] = '{128'h4e3c7f1a92d05b6e8f1120aa37c4d9e5, 8'd3, 8'd0, 16'hc000, 16'h0000,
                    32'h4, 1'b0, 1'b0};
        rows[4] = '{128'hacbef20579b4b8ebce889bac8732dad7, 8'd0, 8'd2, 16'h0000, 16'hffff,
                    32'h5, 1'b0, 1'b0};
        rows[5] = '{128'h0123456789abcdeffedcba9876543210, 8'd4, 8'd5, 16'hffff, 16'hfe00,
                    32'h6, 1'b0, 1'b0};
        rows[6] = '{128'h9e0f1c2d3b4a59687786a5b4c3d2e1f0, 8'd1, 8'd2, 16'h8000, 16'hffff,
                    32'h7, 1'b0, 1'b1};

        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        if (busy !== 1'b0) begin
            $display("ERR busy after reset: got %h, expected %h", busy, 1'b0);
            err_count++;
        end
        if (tag !== '0) begin
            $display("ERR tag after reset: got %h, expected %h", tag, 128'h0);
            err_count++;
        end
        if (tag_valid !== 1'b0) begin
            $display("ERR tag_valid after reset: got %h, expected %h", tag_valid, 1'b0);
            err_count++;
        end
        if (aad_ready !== 1'b0) begin
            $display("ERR aad_ready after reset: got %h, expected %h", aad_ready, 1'b0);
            err_count++;
        end
        if (ct_ready !== 1'b0) begin
            $display("ERR ct_ready after reset: got %h, expected %h", ct_ready, 1'b0);
            err_count++;
        end
        @(posedge clk);
        #1;

        for (int r = 0; r < NUM_ROWS && !aborted; r++) begin
            // Build the beats and the expected tag
            n_aad      = rows[r].n_aad;
            n_ct       = rows[r].n_ct;
            rand_state = 32'hbae0 ^ rows[r].seed;
            y          = '0;
            for (int i = 0; i < n_aad; i++) begin
                draw_block(blk);
                aad_mem[i] = blk;
                k = (i == n_aad - 1) ? rows[r].aad_keep : '1;
                y = gf_mult(y ^ apply_keep(blk, k), rows[r].h);
            end
            for (int i = 0; i < n_ct; i++) begin
                draw_block(blk);
                if (rows[r].fixed_ct && i == 0) begin
                    blk = TC2_CT;
                end
                ct_mem[i] = blk;
                k = (i == n_ct - 1) ? rows[r].ct_keep : '1;
                y = gf_mult(y ^ apply_keep(blk, k), rows[r].h);
            end
            la       = section_bits(n_aad, rows[r].aad_keep);
            lc       = section_bits(n_ct, rows[r].ct_keep);
            expected = gf_mult(y ^ {la, lc}, rows[r].h);
            if (rows[r].fixed_ct && expected !== TC2_GHASH) begin
                $display("Reference model does not reproduce the GCM test case 2 hash");
                err_count++;
            end

            hash_key     = rows[r].h;
            len_aad_bits = la;
            len_ct_bits  = lc;
            start        = 1'b1;
            @(posedge clk);
            #1;
            start = 1'b0;
            @(negedge clk);
            if (busy !== 1'b1) begin
                $display("ERR busy after start: got %h, expected %h", busy, 1'b1);
                err_count++;
            end
            @(posedge clk);
            #1;

            stall_count = 0;
            ok          = 1'b1;
            for (int i = 0; i < n_aad && ok; i++) begin
                k = (i == n_aad - 1) ? rows[r].aad_keep : '1;
                send_beat(1'b0, aad_mem[i], k, i == n_aad - 1, ok);
            end
            for (int i = 0; i < n_ct && ok; i++) begin
                k = (i == n_ct - 1) ? rows[r].ct_keep : '1;
                send_beat(1'b1, ct_mem[i], k, i == n_ct - 1, ok);
            end
            if (ok) begin
                if (n_aad + n_ct > `GHASH_FIFO_DEPTH + 2 && stall_count == 0) begin
                    $display("Row %0d never saw the stream ready signals drop", r);
                    err_count++;
                end
                wait_tag(expected, rows[r].extra_start, ok);
            end
            if (!ok) begin
                timeout_count++;
                aborted = 1'b1;
            end
        end

        $display("Checks done: %0d mismatches, %0d timeouts", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+include
source/ghash_pkg.sv
source/ghash_block_framer.sv
source/ghash_block_fifo.sv
source/ghash_accumulator.sv
source/ghash_engine_top.sv
tb/tb_ghash_engine.sv
